/* link_rx_top.f */
+incdir+.
link_rx_pkg.sv
msg_stream_if.sv
block_dequeue.sv
msg_merge.sv
link_rx_top.sv
link_rx_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the link receiver testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f link_rx_top.f --top-module link_rx_tb -o sim_link_rx
status=$?
if [ $status -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/sim_link_rx > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
  exit 1
fi

if ! grep -q "PASS: all tests" "$LOG"; then
  echo "no result found in $LOG"
  exit 1
fi

exit 0

/* link_rx_tb_model.svh */
/*
  Testbench model of the link receiver: random numbers and
  expected-message queues with their window computation
*/

`ifndef LINK_RX_TB_MODEL_SVH
`define LINK_RX_TB_MODEL_SVH

////////////////////
// Random numbers
////////////////////

logic [31:0] lcg_state = 32'd50;

// Upper state bits, the low ones repeat too quickly
function automatic logic [15:0] next_rand();
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return lcg_state[30:15];
endfunction

////////////////////
// Expected messages
////////////////////

logic [MSG_WIDTH_MAX-1:0] exp_data_a[$];
logic                     exp_first_a[$];
logic [MSG_WIDTH_MAX-1:0] exp_data_b[$];
logic                     exp_first_b[$];

// Payloads of block k upward, start bits dropped, moved down to bit 0
function automatic logic [MSG_WIDTH_MAX-1:0] window_of(input logic [31:0] word,
                                                      input int nblk, input int k);
  logic [MSG_WIDTH_MAX-1:0] w;
  w = '0;
  for (int j = k; j < nblk; j++) begin
    w[(j-k)*PAYLOAD_BITS +: PAYLOAD_BITS] = word[j*BLOCK_SIZE+1 +: PAYLOAD_BITS];
  end
  return w;
endfunction

// One message per start bit, first flag on the lowest one
task automatic push_messages(input chan_id_t chan, input logic [31:0] word,
                             input int nblk);
  logic first;
  first = 1'b1;
  for (int k = 0; k < nblk; k++) begin
    if (word[k*BLOCK_SIZE + START_BIT]) begin
      if (chan == CHAN_A) begin
        exp_data_a.push_back(window_of(word, nblk, k));
        exp_first_a.push_back(first);
      end else begin
        exp_data_b.push_back(window_of(word, nblk, k));
        exp_first_b.push_back(first);
      end
      first = 1'b0;
    end
  end
endtask

`endif

/* link_rx_tb.sv */
/*
  Testbench of the link receiver: clock, reset, random words,
  output checking against the model, watchdog and summary
*/

`timescale 1ns/10ps

module link_rx_tb
  import link_rx_pkg::*;
;

  localparam int RESET_CYCLES = 8;
  localparam int NUM_CYCLES   = 3000;
  localparam int DRAIN_CYCLES = 200;
  localparam int TOTAL_CYCLES = RESET_CYCLES + NUM_CYCLES + DRAIN_CYCLES;

  logic                     clk_i;
  logic                     reset_i;
  logic                     a_valid_i;
  logic                     a_ready_o;
  logic [WORD_WIDTH_A-1:0]  a_data_i;
  logic                     b_valid_i;
  logic                     b_ready_o;
  logic [WORD_WIDTH_B-1:0]  b_data_i;
  logic                     out_valid_o;
  logic                     out_ready_i;
  logic [MSG_WIDTH_MAX-1:0] out_data_o;
  chan_id_t                 out_chan_o;
  logic                     out_first_o;

  // Error counts of the six checked behaviours
  int err_window;
  int err_count;
  int err_first;
  int err_hold;
  int err_fair;
  int err_reset;
  int checks;
  int errors;

  // Held output under back-pressure
  logic                     hold_pending;
  logic [MSG_WIDTH_MAX-1:0] hold_data;
  chan_id_t                 hold_chan;
  logic                     hold_first;

  // Run of outputs from one channel
  chan_id_t                 last_chan;
  int                       run_len;

  `include "link_rx_tb_model.svh"

  link_rx_top dut (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .a_valid_i   (a_valid_i),
    .a_ready_o   (a_ready_o),
    .a_data_i    (a_data_i),
    .b_valid_i   (b_valid_i),
    .b_ready_o   (b_ready_o),
    .b_data_i    (b_data_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (out_data_o),
    .out_chan_o  (out_chan_o),
    .out_first_o (out_first_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Watchdog
  initial begin
    #(TOTAL_CYCLES * 20 * 100);
    $display("watchdog: the run did not finish in the expected time");
    $display("FAIL: see errors above");
    $finish;
  end

  ////////////////////
  // Output checks
  ////////////////////

  task automatic check_output();
    logic [MSG_WIDTH_MAX-1:0] exp_d;
    logic                     exp_f;
    int                       other_len;
    int                       run_max;
    // Message held by back-pressure must stay unchanged
    if (hold_pending) begin
      checks++;
      if (!out_valid_o || out_data_o != hold_data || out_chan_o != hold_chan
          || out_first_o != hold_first) begin
        $display("FAILED hold: expected %h, actual %h", hold_data, out_data_o);
        err_hold++;
      end
      hold_pending = 1'b0;
    end
    if (out_valid_o && out_ready_i) begin
      if ((out_chan_o == CHAN_A && exp_data_a.size() == 0)
          || (out_chan_o == CHAN_B && exp_data_b.size() == 0)) begin
        $display("message on channel %0d that the model does not expect", out_chan_o);
        err_count++;
      end else begin
        if (out_chan_o == CHAN_A) begin
          exp_d = exp_data_a.pop_front();
          exp_f = exp_first_a.pop_front();
          other_len = exp_data_b.size();
        end else begin
          exp_d = exp_data_b.pop_front();
          exp_f = exp_first_b.pop_front();
          other_len = exp_data_a.size();
        end
        checks += 2;
        if (out_data_o != exp_d) begin
          $display("FAILED window: expected %h, actual %h", exp_d, out_data_o);
          err_window++;
        end
        if (out_first_o != exp_f) begin
          $display("FAILED first: expected %h, actual %h", exp_f, out_first_o);
          err_first++;
        end
        // Count a run only while the other channel has work queued
        if (other_len == 0) begin
          run_len = 0;
        end else if (run_len > 0 && out_chan_o == last_chan) begin
          run_len++;
        end else begin
          run_len = 1;
        end
        // The other dequeuer may spend one cycle per block
        // before its next start block reaches the front
        run_max = (out_chan_o == CHAN_A) ? NUM_BLOCKS_B : NUM_BLOCKS_A;
        checks++;
        if (run_len > run_max) begin
          $display("FAILED fairness: expected at most %0d, actual %0d", run_max, run_len);
          err_fair++;
        end
        last_chan = out_chan_o;
      end
    end else if (out_valid_o) begin
      hold_pending = 1'b1;
      hold_data    = out_data_o;
      hold_chan    = out_chan_o;
      hold_first   = out_first_o;
    end
  endtask

  ////////////////////
  // One clock step
  ////////////////////

  task automatic step(input logic allow_new);
    check_output();
    if (a_valid_i && a_ready_o) begin
      push_messages(CHAN_A, 32'(a_data_i), NUM_BLOCKS_A);
    end
    if (b_valid_i && b_ready_o) begin
      push_messages(CHAN_B, 32'(b_data_i), NUM_BLOCKS_B);
    end
    // A word on offer stays until it is taken
    if (!a_valid_i || a_ready_o) begin
      a_valid_i <= allow_new && (next_rand() % 4 != 0);
      a_data_i  <= {next_rand(), next_rand()};
    end
    if (!b_valid_i || b_ready_o) begin
      b_valid_i <= allow_new && (next_rand() % 4 != 0);
      b_data_i  <= next_rand();
    end
    out_ready_i <= next_rand() % 2;
  endtask

  task automatic report(input string name, input int errs);
    if (errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errs);
    end
  endtask

  initial begin
    int drain;
    reset_i      = 1'b1;
    a_valid_i    = 1'b0;
    a_data_i     = '0;
    b_valid_i    = 1'b0;
    b_data_i     = '0;
    out_ready_i  = 1'b0;
    hold_pending = 1'b0;
    run_len      = 0;
    last_chan    = CHAN_A;
    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    @(negedge clk_i);
    checks++;
    if (out_valid_o || !a_ready_o || !b_ready_o) begin
      $display("after reset the output is valid or an input is not ready");
      err_reset++;
    end
    repeat (NUM_CYCLES) begin
      @(posedge clk_i);
      step(1'b1);
    end
    // Let everything in flight come out
    drain = 0;
    while (drain < DRAIN_CYCLES && (exp_data_a.size() != 0
           || exp_data_b.size() != 0 || a_valid_i || b_valid_i || out_valid_o)) begin
      @(posedge clk_i);
      step(1'b0);
      drain++;
    end
    checks++;
    if (exp_data_a.size() != 0 || exp_data_b.size() != 0) begin
      $display("expected messages never came out: %0d on A, %0d on B",
               exp_data_a.size(), exp_data_b.size());
      err_count++;
    end
    report("window", err_window);
    report("count", err_count);
    report("first", err_first);
    report("backpressure", err_hold);
    report("fairness", err_fair);
    report("reset", err_reset);
    errors = err_window + err_count + err_first + err_hold + err_fair + err_reset;
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* link_rx_top.sv */
/*
  Receive side of the two-channel link: one dequeuer per
  channel feeding a round-robin merger
*/

`timescale 1ns/10ps

module link_rx_top
  import link_rx_pkg::*;
#(
  parameter int BlockSize  = BLOCK_SIZE,
  parameter int NumBlocksA = NUM_BLOCKS_A,
  parameter int NumBlocksB = NUM_BLOCKS_B
) (
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  // Channel A words
  input  logic                                        a_valid_i,
  output logic                                        a_ready_o,
  input  logic [NumBlocksA*BlockSize-1:0]             a_data_i,
  // Channel B words
  input  logic                                        b_valid_i,
  output logic                                        b_ready_o,
  input  logic [NumBlocksB*BlockSize-1:0]             b_data_i,
  // Merged messages
  output logic                                        out_valid_o,
  input  logic                                        out_ready_i,
  output logic [(NumBlocksA > NumBlocksB ? NumBlocksA : NumBlocksB)
                * (BlockSize-1)-1:0]                  out_data_o,
  output chan_id_t                                    out_chan_o,
  output logic                                        out_first_o
);

  // Window of the wider channel, the other one is zero-extended
  localparam int MaxBlocks = (NumBlocksA > NumBlocksB) ? NumBlocksA : NumBlocksB;
  localparam int MsgWidth  = MaxBlocks * (BlockSize - 1);

  // Raw word type of each channel
  localparam type word_a_t = logic [NumBlocksA*BlockSize-1:0];
  localparam type word_b_t = logic [NumBlocksB*BlockSize-1:0];

  msg_stream_if #(.DataWidth(MsgWidth)) msg_a ();
  msg_stream_if #(.DataWidth(MsgWidth)) msg_b ();

  ////////////////////
  // Dequeuers
  ////////////////////

  block_dequeue #(
    .data_i_t  (word_a_t),
    .BlockSize (BlockSize),
    .OutWidth  (MsgWidth)
  ) u_deq_a (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (a_valid_i),
    .ready_o (a_ready_o),
    .data_i  (a_data_i),
    .msg_o   (msg_a.src)
  );

  block_dequeue #(
    .data_i_t  (word_b_t),
    .BlockSize (BlockSize),
    .OutWidth  (MsgWidth)
  ) u_deq_b (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (b_valid_i),
    .ready_o (b_ready_o),
    .data_i  (b_data_i),
    .msg_o   (msg_b.src)
  );

  ////////////////////
  // Merger
  ////////////////////

  msg_merge #(
    .DataWidth (MsgWidth)
  ) u_merge (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_a        (msg_a.dst),
    .in_b        (msg_b.dst),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (out_data_o),
    .out_chan_o  (out_chan_o),
    .out_first_o (out_first_o)
  );

endmodule

/* msg_merge.sv */
/*
  Round-robin merger of two message streams into one
  registered output stream tagged with its channel number
*/

`timescale 1ns/10ps

module msg_merge
  import link_rx_pkg::*;
#(
  parameter int DataWidth = 28
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  // Dequeued streams of channel A and B
  msg_stream_if.dst            in_a,
  msg_stream_if.dst            in_b,
  // Merged output stream
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic [DataWidth-1:0] out_data_o,
  output chan_id_t             out_chan_o,
  output logic                 out_first_o
);

  logic                 out_valid_q;
  logic [DataWidth-1:0] out_data_q;
  chan_id_t             out_chan_q;
  logic                 out_first_q;

  // Channel that wins a tie
  chan_id_t             rr_q;

  logic                 can_load;
  logic                 grant_a;
  logic                 grant_b;

  ////////////////////
  // Arbitration
  ////////////////////

  // Register free or being emptied this cycle
  assign can_load = ~out_valid_q | out_ready_i;

  // A lone request always wins, a tie goes to the pointer
  assign grant_a = can_load & in_a.valid & (~in_b.valid | (rr_q == CHAN_A));
  assign grant_b = can_load & in_b.valid & (~in_a.valid | (rr_q == CHAN_B));

  // Loser just sees ready low and keeps its message
  assign in_a.ready = grant_a;
  assign in_b.ready = grant_b;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_q <= CHAN_A;
    end else if (grant_a) begin
      rr_q <= CHAN_B;
    end else if (grant_b) begin
      rr_q <= CHAN_A;
    end
  end

  ////////////////////
  // Output register
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_valid_q <= 1'b0;
    end else if (can_load) begin
      out_valid_q <= grant_a | grant_b;
    end
  end

  // Payload needs no reset, it is qualified by valid
  always_ff @(posedge clk_i) begin
    if (grant_a) begin
      out_data_q  <= in_a.data;
      out_first_q <= in_a.first;
      out_chan_q  <= CHAN_A;
    end else if (grant_b) begin
      out_data_q  <= in_b.data;
      out_first_q <= in_b.first;
      out_chan_q  <= CHAN_B;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_data_o  = out_data_q;
  assign out_chan_o  = out_chan_q;
  assign out_first_o = out_first_q;

  ////////////////////
  // Assertions
  ////////////////////

  // At most one dequeuer hands over a message per cycle
  a_one_grant: assert property (@(posedge clk_i) disable iff (reset_i)
    !(in_a.ready && in_b.ready));

  // A stalled output keeps its message unchanged
  a_out_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o)
      && $stable(out_chan_o) && $stable(out_first_o));

endmodule

/* block_dequeue.sv */
/*
  Block dequeuer for one channel: loads a word of start-bit
  interleaved blocks, shifts it down one block per cycle and
  offers a start-aligned message window per start bit
*/

`timescale 1ns/10ps

////////////////////
// Word layout
////////////////////
//
//  |ppppppp s|ppppppp s| ... |ppppppp s|
//   block N-1             ...   block 0
//
//  p = payload, s = start bit of a message
//  Block 0 is the lowest byte and reaches the front first

module block_dequeue #(
  // Raw input word of the channel
  parameter type data_i_t  = logic [15:0],
  parameter int  BlockSize = 8,
  // Width of the window handed to the merger
  parameter int  OutWidth  = 14
) (
  input  logic    clk_i,
  input  logic    reset_i,
  // Word input
  input  logic    valid_i,
  output logic    ready_o,
  input  data_i_t data_i,
  // Message output
  msg_stream_if.src msg_o
);

  localparam int NumBlocks = $bits(data_i_t) / BlockSize;
  localparam int WinWidth  = NumBlocks * (BlockSize - 1);
  localparam int IdxWidth  = $clog2(NumBlocks);

  typedef logic [NumBlocks-1:0][BlockSize-1:0] blocks_t;

  // Block register, payload only so no reset
  blocks_t blk_q, blk_d;
  // Control state
  logic                full_q, full_d;
  logic [IdxWidth-1:0] idx_q, idx_d;
  logic                first_q, first_d;

  logic                front_start;
  logic                last;
  logic                stall;
  logic                xfer;
  logic                load;
  logic                shift;
  logic [WinWidth-1:0] win;

  ////////////////////
  // Handshake
  ////////////////////

  // Front block opens a message
  assign front_start = blk_q[0][0];
  assign last        = (idx_q == IdxWidth'(NumBlocks - 1));

  assign msg_o.valid = full_q & front_start;
  assign msg_o.first = first_q;

  assign xfer  = msg_o.valid & msg_o.ready;
  assign stall = msg_o.valid & ~msg_o.ready;

  // Accept when empty, or when the last block leaves this cycle
  assign ready_o = ~full_q | (last & (~front_start | msg_o.ready));
  assign load    = valid_i & ready_o;

  // Move forward unless the window is held or nothing is behind it
  assign shift = full_q & ~stall & ~last;

  ////////////////////
  // Block register
  ////////////////////

  always_comb begin
    blk_d = blk_q;
    if (load) begin
      blk_d = blocks_t'(data_i);
    end else if (shift) begin
      // Drop the front block, zero enters at the top
      blk_d = blocks_t'({BlockSize'(0), blk_q[NumBlocks-1:1]});
    end
  end

  always_comb begin
    full_d  = full_q;
    idx_d   = idx_q;
    first_d = first_q;
    // Register empties after the last block unless a new word arrives
    if (ready_o) begin
      full_d = valid_i;
    end
    if (shift) begin
      idx_d = idx_q + 1'b1;
    end
    if (xfer) begin
      first_d = 1'b0;
    end
    // A fresh word restarts counting and rearms the first flag
    if (load) begin
      idx_d   = '0;
      first_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    blk_q <= blk_d;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_q  <= 1'b0;
      idx_q   <= '0;
      first_q <= 1'b0;
    end else begin
      full_q  <= full_d;
      idx_q   <= idx_d;
      first_q <= first_d;
    end
  end

  ////////////////////
  // Window
  ////////////////////

  // Strip the start bit of every block and pack the payloads
  always_comb begin
    for (int i = 0; i < NumBlocks; i++) begin
      win[i*(BlockSize-1) +: (BlockSize-1)] = blk_q[i][BlockSize-1:1];
    end
  end

  // Zero-extend to the shared output width
  assign msg_o.data = OutWidth'(win);

  ////////////////////
  // Assertions
  ////////////////////

  // Shifting needs at least two blocks in a whole word
  a_block_count: assert property (@(posedge clk_i)
    (NumBlocks >= 2) && ($bits(data_i_t) == NumBlocks * BlockSize));

  // An offered window stays put until the merger takes it
  a_valid_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    msg_o.valid && !msg_o.ready |=> msg_o.valid && $stable(msg_o.data)
      && $stable(msg_o.first));

  // Counter stays within the word
  a_idx_range: assert property (@(posedge clk_i) disable iff (reset_i)
    full_q |-> idx_q <= IdxWidth'(NumBlocks - 1));

endmodule

/* msg_stream_if.sv */
/*
  Message stream bundle: valid/ready handshake, window data
  and the first-message flag, with source and sink views
*/

`timescale 1ns/10ps

interface msg_stream_if #(
  // Width of the message window
  parameter int DataWidth = 28
);

  // Source holds a message on offer
  logic                 valid;
  // Sink takes the message on this edge
  logic                 ready;
  // Start-aligned window, start bits already removed
  logic [DataWidth-1:0] data;
  // Set on the first message taken from an input word
  logic                 first;

  // Producer side, used by the dequeuer
  modport src (
    output valid,
    output data,
    output first,
    input  ready
  );

  // Consumer side, used by the merger
  modport dst (
    input  valid,
    input  data,
    input  first,
    output ready
  );

endinterface

/* link_rx_pkg.sv */
/*
  Shared definitions of the two-channel link receiver:
  block geometry, channel numbers and derived widths
*/

package link_rx_pkg;

  ////////////////////
  // Block geometry
  ////////////////////

  // One block is seven payload bits above a start bit at bit 0
  localparam int BLOCK_SIZE = 8;

  // Position of the start bit inside a block
  localparam int START_BIT = 0;

  // Payload bits left in a block once the start bit is dropped
  localparam int PAYLOAD_BITS = BLOCK_SIZE - 1;

  // Default block counts per channel
  localparam int NUM_BLOCKS_A = 4;
  localparam int NUM_BLOCKS_B = 2;

  // Raw input word widths at the defaults
  localparam int WORD_WIDTH_A = NUM_BLOCKS_A * BLOCK_SIZE;
  localparam int WORD_WIDTH_B = NUM_BLOCKS_B * BLOCK_SIZE;

  ////////////////////
  // Message windows
  ////////////////////

  // Window width of each channel before zero extension
  localparam int MSG_WIDTH_A = NUM_BLOCKS_A * PAYLOAD_BITS;
  localparam int MSG_WIDTH_B = NUM_BLOCKS_B * PAYLOAD_BITS;

  // Width of the merged output window, B is zero-extended up to it
  localparam int MSG_WIDTH_MAX = NUM_BLOCKS_A * (BLOCK_SIZE - 1);

  ////////////////////
  // Channel numbers
  ////////////////////

  localparam int NUM_CHANNELS = 2;

  // 0 selects channel A, 1 selects channel B
  typedef logic chan_id_t;

  localparam chan_id_t CHAN_A = 1'b0;
  localparam chan_id_t CHAN_B = 1'b1;

endpackage
